/* include/l2_decoder_macros.svh */
`ifndef L2_DECODER_MACROS_SVH
`define L2_DECODER_MACROS_SVH

// cpu byte address width
`define ADDR_BITS 32

// offset inside one cache line
`define OFFSET_BITS 4
// word select within the line
`define W_OFF_BITS 2
// byte select within the word
`define B_OFF_BITS 2

// line address drops the offset bits
`define LINE_ADDR_BITS (`ADDR_BITS - `OFFSET_BITS)

// l2 set index
`define L2_SET_BITS 4
`define L2_SETS 16

// l2 ways per set
`define L2_WAY_BITS 2
`define L2_WAYS 4

// tag sits above set and offset
`define L2_TAG_BITS (`LINE_ADDR_BITS - `L2_SET_BITS)

// miss status holding registers
`define N_MSHR 8
// free count needs one extra bit to reach N_MSHR
`define REQS_BITS_P1 4

`endif

/* design/l2_decoder_pkg.sv */
`include "l2_decoder_macros.svh"

package l2_decoder_pkg;

    // action taken by the decoder in one cycle
    typedef enum logic [2:0] {
        act_idle,
        act_fence,
        act_ongoing_fence,
        act_rsp,
        act_fwd,
        act_flush,
        act_cpu_req
    } decode_action_t;

    // flush walker state
    typedef enum logic {
        flush_idle,
        flush_walk
    } flush_state_t;

    // input valids, one per class
    typedef struct packed {
        logic fence;
        logic flush;
        logic rsp;
        logic fwd;
        logic cpu_req;
    } in_valid_t;

    // matching readies
    typedef struct packed {
        logic fence;
        logic flush;
        logic rsp;
        logic fwd;
        logic cpu_req;
    } in_ready_t;

    // stall and conflict flags from the surrounding pipeline
    typedef struct packed {
        logic evict_stall;
        logic set_conflict;
        logic fwd_stall;
        logic fwd_stall_ended;
        logic ongoing_fence;
        logic drain_in_progress;
    } pipe_status_t;

    // arbiter to walker, at most one bit set
    typedef struct packed {
        logic start;
        logic step;
        logic wrap;
        logic finish;
    } flush_cmd_t;

    // walker to arbiter and register
    typedef struct packed {
        logic                  active;
        logic                  at_way_end;
        logic                  at_set_end;
        // one extra bit so the walk can reach L2_SETS
        logic [`L2_SET_BITS:0] set;
    } flush_status_t;

    typedef struct packed {
        logic [`L2_TAG_BITS-1:0] tag;
        logic [`L2_SET_BITS-1:0] set;
    } line_breakdown_t;

    typedef struct packed {
        logic [`ADDR_BITS-1:0]      line;
        logic [`LINE_ADDR_BITS-1:0] line_addr;
        logic [`ADDR_BITS-1:0]      word;
        logic [`L2_TAG_BITS-1:0]    tag;
        logic [`L2_SET_BITS-1:0]    set;
        logic [`W_OFF_BITS-1:0]     w_off;
        logic [`B_OFF_BITS-1:0]     b_off;
    } addr_breakdown_t;

endpackage

/* design/l2_input_arbiter.sv */
`timescale 1ns/10ps
`include "l2_decoder_macros.svh"

module l2_input_arbiter (
    input  logic                           decode_en,
    input  l2_decoder_pkg::in_valid_t      valid,
    input  l2_decoder_pkg::pipe_status_t   status,
    input  logic [`REQS_BITS_P1-1:0]       mshr_cnt,
    input  logic [`LINE_ADDR_BITS-1:0]     rsp_in_addr,
    input  logic [`LINE_ADDR_BITS-1:0]     fwd_in_tmp_addr,
    input  l2_decoder_pkg::flush_status_t  flush_stat,
    output l2_decoder_pkg::in_ready_t      ready,
    output logic                           set_cpu_req_from_conflict,
    output logic                           set_fwd_in_from_stalled,
    output l2_decoder_pkg::flush_cmd_t     flush_cmd,
    output logic                           flush_done,
    output l2_decoder_pkg::decode_action_t next_action
);

    localparam logic [`REQS_BITS_P1-1:0] mshr_all_free = `N_MSHR;

    logic all_free;
    logic fwd_take;
    logic rsp_ok;
    logic fence_ok;
    logic cpu_ok;

    // nothing outstanding in the mshr
    assign all_free = (mshr_cnt == mshr_all_free);

    // a forward would win this cycle, new or released from stall
    assign fwd_take = (valid.fwd && !status.fwd_stall) || status.fwd_stall_ended;

    // new fence blocked by a running fence or drain
    assign fence_ok = valid.fence && !status.ongoing_fence && !status.drain_in_progress;

    // response needs an outstanding miss
    // and must not overtake a forward to the same line
    assign rsp_ok = valid.rsp && !all_free &&
                    !(valid.fwd && (!status.fwd_stall || status.fwd_stall_ended) &&
                      rsp_in_addr == fwd_in_tmp_addr);

    // cpu side, new or the set-conflicted one
    assign cpu_ok = (valid.cpu_req || status.set_conflict) && mshr_cnt != '0 &&
                    !status.evict_stall && !status.ongoing_fence &&
                    !status.drain_in_progress;

    always_comb begin
        ready = '0;
        flush_cmd = '0;
        set_cpu_req_from_conflict = 1'b0;
        set_fwd_in_from_stalled = 1'b0;
        flush_done = 1'b0;
        next_action = l2_decoder_pkg::act_idle;

        if (decode_en) begin
            if (fence_ok) begin
                ready.fence = 1'b1;
                next_action = l2_decoder_pkg::act_fence;
            end else if (valid.flush && all_free) begin
                // only kicks off the walker, no action of its own
                ready.flush = 1'b1;
                flush_cmd.start = 1'b1;
            end else if (rsp_ok) begin
                ready.rsp = 1'b1;
                next_action = l2_decoder_pkg::act_rsp;
            end else if (fwd_take) begin
                next_action = l2_decoder_pkg::act_fwd;
                if (!status.fwd_stall) begin
                    ready.fwd = 1'b1;
                end else begin
                    // replay the parked forward
                    set_fwd_in_from_stalled = 1'b1;
                end
            end else if (status.ongoing_fence && !status.drain_in_progress) begin
                // self-invalidation once the drain is over
                next_action = l2_decoder_pkg::act_ongoing_fence;
            end else if (flush_stat.active) begin
                if (flush_stat.at_set_end) begin
                    // walked past the last set
                    flush_cmd.finish = 1'b1;
                    flush_done = 1'b1;
                end else if (flush_stat.at_way_end) begin
                    flush_cmd.wrap = 1'b1;
                end else if (!valid.fwd && mshr_cnt != '0) begin
                    // one way per step, needs an mshr slot
                    flush_cmd.step = 1'b1;
                    next_action = l2_decoder_pkg::act_flush;
                end
            end else if (cpu_ok) begin
                next_action = l2_decoder_pkg::act_cpu_req;
                if (!status.set_conflict) begin
                    ready.cpu_req = 1'b1;
                end else begin
                    set_cpu_req_from_conflict = 1'b1;
                end
            end
        end
    end

endmodule

/* design/l2_flush_walker.sv */
`timescale 1ns/10ps
`include "l2_decoder_macros.svh"

module l2_flush_walker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          decode_en,
    input  l2_decoder_pkg::flush_cmd_t    flush_cmd,
    output l2_decoder_pkg::flush_status_t flush_stat,
    output logic [`L2_WAY_BITS:0]         flush_way
);

    localparam logic [`L2_WAY_BITS:0] way_end = `L2_WAYS;
    localparam logic [`L2_SET_BITS:0] set_end = `L2_SETS;

    l2_decoder_pkg::flush_state_t state;
    logic [`L2_SET_BITS:0]        set_cnt;
    logic [`L2_WAY_BITS:0]        way_cnt;

    // counters only move on an enabled decode cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= l2_decoder_pkg::flush_idle;
            set_cnt <= '0;
            way_cnt <= '0;
        end else if (decode_en) begin
            if (flush_cmd.start) begin
                // restart from set 0 way 0
                state <= l2_decoder_pkg::flush_walk;
                set_cnt <= '0;
                way_cnt <= '0;
            end else if (flush_cmd.finish) begin
                state <= l2_decoder_pkg::flush_idle;
                set_cnt <= '0;
                way_cnt <= '0;
            end else if (flush_cmd.wrap) begin
                // all ways of this set done
                way_cnt <= '0;
                set_cnt <= set_cnt + 1'b1;
            end else if (flush_cmd.step) begin
                way_cnt <= way_cnt + 1'b1;
            end
        end
    end

    // status back to arbiter and register
    assign flush_stat.active = (state == l2_decoder_pkg::flush_walk);
    assign flush_stat.at_way_end = (way_cnt == way_end);
    assign flush_stat.at_set_end = (set_cnt == set_end);
    assign flush_stat.set = set_cnt;
    assign flush_way = way_cnt;

    // step stops at the way end and a wrap follows
    way_in_range: assert property (
        @(posedge clk) disable iff (!rst)
        way_cnt <= way_end
    );

    // only a start can wake an idle walker
    idle_only_start: assert property (
        @(posedge clk) disable iff (!rst)
        (state == l2_decoder_pkg::flush_idle && decode_en) |->
            !(flush_cmd.step || flush_cmd.wrap || flush_cmd.finish)
    );

endmodule

/* design/l2_decode_register.sv */
`timescale 1ns/10ps
`include "l2_decoder_macros.svh"

module l2_decode_register (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           decode_en,
    input  l2_decoder_pkg::decode_action_t next_action,
    input  logic [`LINE_ADDR_BITS-1:0]     rsp_in_addr,
    input  logic [`LINE_ADDR_BITS-1:0]     fwd_in_addr,
    input  logic [`ADDR_BITS-1:0]          cpu_req_addr,
    input  l2_decoder_pkg::flush_status_t  flush_stat,
    output l2_decoder_pkg::decode_action_t action,
    output l2_decoder_pkg::line_breakdown_t line_br,
    output l2_decoder_pkg::addr_breakdown_t addr_br
);

    l2_decoder_pkg::line_breakdown_t line_br_next;
    l2_decoder_pkg::addr_breakdown_t addr_br_next;

    // line breakdown for rsp and fwd only
    always_comb begin
        case (next_action)
            l2_decoder_pkg::act_rsp: begin
                line_br_next.tag = rsp_in_addr[`LINE_ADDR_BITS-1:`L2_SET_BITS];
                line_br_next.set = rsp_in_addr[`L2_SET_BITS-1:0];
            end
            l2_decoder_pkg::act_fwd: begin
                line_br_next.tag = fwd_in_addr[`LINE_ADDR_BITS-1:`L2_SET_BITS];
                line_br_next.set = fwd_in_addr[`L2_SET_BITS-1:0];
            end
            default: begin
                line_br_next = '0;
            end
        endcase
    end

    // cpu address slicing
    always_comb begin
        // line aligned, offset zeroed
        addr_br_next.line = {cpu_req_addr[`ADDR_BITS-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
        addr_br_next.line_addr = cpu_req_addr[`ADDR_BITS-1:`OFFSET_BITS];
        // word aligned, byte bits zeroed
        addr_br_next.word = {cpu_req_addr[`ADDR_BITS-1:`B_OFF_BITS], {`B_OFF_BITS{1'b0}}};
        addr_br_next.tag = cpu_req_addr[`ADDR_BITS-1:`OFFSET_BITS+`L2_SET_BITS];
        addr_br_next.w_off = cpu_req_addr[`OFFSET_BITS-1:`B_OFF_BITS];
        addr_br_next.b_off = cpu_req_addr[`B_OFF_BITS-1:0];

        // a flush step targets the walker's set, not the cpu one
        // offsets stay from the cpu address since flushes are whole lines
        if (next_action == l2_decoder_pkg::act_flush) begin
            addr_br_next.set = flush_stat.set[`L2_SET_BITS-1:0];
        end else begin
            addr_br_next.set = cpu_req_addr[`OFFSET_BITS+`L2_SET_BITS-1:`OFFSET_BITS];
        end
    end

    // one cycle decode latency, held while decode_en is low
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            action <= l2_decoder_pkg::act_idle;
            line_br <= '0;
            addr_br <= '0;
        end else if (decode_en) begin
            action <= next_action;
            line_br <= line_br_next;
            addr_br <= addr_br_next;
        end
    end

    // flush set substitution only valid while a walk is below the last set
    flush_set_valid: assert property (
        @(posedge clk) disable iff (!rst)
        (decode_en && next_action == l2_decoder_pkg::act_flush) |->
            (flush_stat.active && !flush_stat.at_set_end)
    );

endmodule

/* design/l2_input_decoder.sv */
`timescale 1ns/10ps
`include "l2_decoder_macros.svh"

module l2_input_decoder (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            decode_en,
    input  l2_decoder_pkg::in_valid_t       valid,
    input  l2_decoder_pkg::pipe_status_t    status,
    input  logic [`REQS_BITS_P1-1:0]        mshr_cnt,
    input  logic [`LINE_ADDR_BITS-1:0]      rsp_in_addr,
    input  logic [`LINE_ADDR_BITS-1:0]      fwd_in_addr,
    input  logic [`LINE_ADDR_BITS-1:0]      fwd_in_tmp_addr,
    input  logic [`ADDR_BITS-1:0]           cpu_req_addr,
    output l2_decoder_pkg::in_ready_t       ready,
    output logic                            set_cpu_req_from_conflict,
    output logic                            set_fwd_in_from_stalled,
    output logic                            flush_done,
    output l2_decoder_pkg::decode_action_t  action,
    output l2_decoder_pkg::line_breakdown_t line_br,
    output l2_decoder_pkg::addr_breakdown_t addr_br
);

    localparam logic [`L2_WAY_BITS:0] way_end = `L2_WAYS;

    l2_decoder_pkg::flush_cmd_t     flush_cmd;
    l2_decoder_pkg::flush_status_t  flush_stat;
    l2_decoder_pkg::decode_action_t next_action;
    logic [`L2_WAY_BITS:0]          flush_way;

    // priority choice, readies and walker commands
    l2_input_arbiter u_arbiter (
        .decode_en                 (decode_en),
        .valid                     (valid),
        .status                    (status),
        .mshr_cnt                  (mshr_cnt),
        .rsp_in_addr               (rsp_in_addr),
        .fwd_in_tmp_addr           (fwd_in_tmp_addr),
        .flush_stat                (flush_stat),
        .ready                     (ready),
        .set_cpu_req_from_conflict (set_cpu_req_from_conflict),
        .set_fwd_in_from_stalled   (set_fwd_in_from_stalled),
        .flush_cmd                 (flush_cmd),
        .flush_done                (flush_done),
        .next_action               (next_action)
    );

    // set and way walk of a flush
    l2_flush_walker u_walker (
        .clk        (clk),
        .rst        (rst),
        .decode_en  (decode_en),
        .flush_cmd  (flush_cmd),
        .flush_stat (flush_stat),
        .flush_way  (flush_way)
    );

    // registered action and breakdowns
    l2_decode_register u_register (
        .clk          (clk),
        .rst          (rst),
        .decode_en    (decode_en),
        .next_action  (next_action),
        .rsp_in_addr  (rsp_in_addr),
        .fwd_in_addr  (fwd_in_addr),
        .cpu_req_addr (cpu_req_addr),
        .flush_stat   (flush_stat),
        .action       (action),
        .line_br      (line_br),
        .addr_br      (addr_br)
    );

    // a flush step always lands on a real way
    flush_step_way: assert property (
        @(posedge clk) disable iff (!rst)
        (decode_en && next_action == l2_decoder_pkg::act_flush) |-> (flush_way < way_end)
    );

    // walker goes idle right after done
    done_then_idle: assert property (
        @(posedge clk) disable iff (!rst)
        flush_done |=> !flush_stat.active
    );

endmodule

/* sim/l2_input_decoder_tb.sv */
`timescale 1ns/10ps
`include "l2_decoder_macros.svh"

module l2_input_decoder_tb;

    localparam int num_cycles = 4000;
    // random run plus margin for reset and the final checks
    localparam int timeout_cycles = num_cycles + 1000;
    localparam logic [`ADDR_BITS-1:0] line_mask = ~((1 << `OFFSET_BITS) - 1);
    localparam logic [`ADDR_BITS-1:0] word_mask = ~((1 << `B_OFF_BITS) - 1);

    logic                                clk;
    logic                                rst;
    logic                                decode_en;
    l2_decoder_pkg::in_valid_t           valid;
    l2_decoder_pkg::pipe_status_t        status;
    logic [`REQS_BITS_P1-1:0]            mshr_cnt;
    logic [`LINE_ADDR_BITS-1:0]          rsp_in_addr;
    logic [`LINE_ADDR_BITS-1:0]          fwd_in_addr;
    logic [`LINE_ADDR_BITS-1:0]          fwd_in_tmp_addr;
    logic [`ADDR_BITS-1:0]               cpu_req_addr;
    l2_decoder_pkg::in_ready_t           ready;
    logic                                set_cpu_req_from_conflict;
    logic                                set_fwd_in_from_stalled;
    logic                                flush_done;
    l2_decoder_pkg::decode_action_t      action;
    l2_decoder_pkg::line_breakdown_t     line_br;
    l2_decoder_pkg::addr_breakdown_t     addr_br;

    // model outputs for the current cycle
    l2_decoder_pkg::in_ready_t           exp_ready;
    logic                                exp_conf;
    logic                                exp_stalled;
    logic                                exp_done;
    l2_decoder_pkg::decode_action_t      exp_next;
    logic                                cmd_start;
    logic                                cmd_step;
    logic                                cmd_wrap;
    logic                                cmd_finish;

    // model registers and walker
    l2_decoder_pkg::decode_action_t      m_action;
    l2_decoder_pkg::line_breakdown_t     m_line;
    l2_decoder_pkg::addr_breakdown_t     m_addr;
    logic                                m_active;
    logic [`L2_SET_BITS:0]               m_set;
    logic [`L2_WAY_BITS:0]               m_way;

    integer seed;
    int     mismatch_count;
    int     other_count;
    int     cycle_count;
    int     flushes_started;
    int     flushes_completed;
    int     done_pulses;

    l2_input_decoder l2_input_decoder_inst (
        .clk                       (clk),
        .rst                       (rst),
        .decode_en                 (decode_en),
        .valid                     (valid),
        .status                    (status),
        .mshr_cnt                  (mshr_cnt),
        .rsp_in_addr               (rsp_in_addr),
        .fwd_in_addr               (fwd_in_addr),
        .fwd_in_tmp_addr           (fwd_in_tmp_addr),
        .cpu_req_addr              (cpu_req_addr),
        .ready                     (ready),
        .set_cpu_req_from_conflict (set_cpu_req_from_conflict),
        .set_fwd_in_from_stalled   (set_fwd_in_from_stalled),
        .flush_done                (flush_done),
        .action                    (action),
        .line_br                   (line_br),
        .addr_br                   (addr_br)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // true with the given percent chance
    function automatic logic chance(input int pct);
        chance = ({$random(seed)} % 100) < pct;
    endfunction

    task compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task drive_inputs;
        decode_en = chance(90);
        valid.fence = chance(4);
        // rare so a walk can finish before the next restart
        valid.flush = chance(2);
        valid.rsp = chance(25);
        valid.fwd = chance(15);
        valid.cpu_req = chance(50);
        status.evict_stall = chance(10);
        status.set_conflict = chance(10);
        status.fwd_stall = chance(15);
        // stall can only end while stalled
        status.fwd_stall_ended = status.fwd_stall && chance(50);
        status.ongoing_fence = chance(5);
        status.drain_in_progress = chance(5);
        if (chance(25)) begin
            mshr_cnt = `N_MSHR;
        end else begin
            mshr_cnt = {$random(seed)} % `N_MSHR;
        end
        rsp_in_addr = $random(seed);
        fwd_in_tmp_addr = chance(30) ? rsp_in_addr : `LINE_ADDR_BITS'($random(seed));
        fwd_in_addr = chance(80) ? fwd_in_tmp_addr : `LINE_ADDR_BITS'($random(seed));
        cpu_req_addr = $random(seed);
    endtask

    // priority choice from the current inputs and walker state
    task decide;
        logic all_free;
        logic fwd_live;
        exp_ready = '0;
        exp_conf = 1'b0;
        exp_stalled = 1'b0;
        exp_done = 1'b0;
        exp_next = l2_decoder_pkg::act_idle;
        {cmd_start, cmd_step, cmd_wrap, cmd_finish} = 4'b0000;
        all_free = (mshr_cnt == `N_MSHR);
        // forward that blocks a response to the same line
        fwd_live = valid.fwd && (!status.fwd_stall || status.fwd_stall_ended);
        if (decode_en) begin
            if (valid.fence && !status.ongoing_fence && !status.drain_in_progress) begin
                exp_ready.fence = 1'b1;
                exp_next = l2_decoder_pkg::act_fence;
            end else if (valid.flush && all_free) begin
                exp_ready.flush = 1'b1;
                cmd_start = 1'b1;
            end else if (valid.rsp && !all_free &&
                         !(fwd_live && rsp_in_addr == fwd_in_tmp_addr)) begin
                exp_ready.rsp = 1'b1;
                exp_next = l2_decoder_pkg::act_rsp;
            end else if ((valid.fwd && !status.fwd_stall) || status.fwd_stall_ended) begin
                exp_next = l2_decoder_pkg::act_fwd;
                if (status.fwd_stall) begin
                    exp_stalled = 1'b1;
                end else begin
                    exp_ready.fwd = 1'b1;
                end
            end else if (status.ongoing_fence && !status.drain_in_progress) begin
                exp_next = l2_decoder_pkg::act_ongoing_fence;
            end else if (m_active) begin
                if (m_set == `L2_SETS) begin
                    cmd_finish = 1'b1;
                    exp_done = 1'b1;
                end else if (m_way == `L2_WAYS) begin
                    cmd_wrap = 1'b1;
                end else if (!valid.fwd && mshr_cnt != 0) begin
                    cmd_step = 1'b1;
                    exp_next = l2_decoder_pkg::act_flush;
                end
            end else if ((valid.cpu_req || status.set_conflict) && mshr_cnt != 0 &&
                         !status.evict_stall && !status.ongoing_fence &&
                         !status.drain_in_progress) begin
                exp_next = l2_decoder_pkg::act_cpu_req;
                if (status.set_conflict) begin
                    exp_conf = 1'b1;
                end else begin
                    exp_ready.cpu_req = 1'b1;
                end
            end
        end
    endtask

    // rising edge of the model, inputs still hold the decided cycle
    task advance_model;
        if (decode_en) begin
            m_action = exp_next;
            m_line = '0;
            if (exp_next == l2_decoder_pkg::act_rsp) begin
                m_line.tag = rsp_in_addr[`LINE_ADDR_BITS-1:`L2_SET_BITS];
                m_line.set = rsp_in_addr[`L2_SET_BITS-1:0];
            end else if (exp_next == l2_decoder_pkg::act_fwd) begin
                m_line.tag = fwd_in_addr[`LINE_ADDR_BITS-1:`L2_SET_BITS];
                m_line.set = fwd_in_addr[`L2_SET_BITS-1:0];
            end
            m_addr.line = cpu_req_addr & line_mask;
            m_addr.line_addr = cpu_req_addr[`ADDR_BITS-1:`OFFSET_BITS];
            m_addr.word = cpu_req_addr & word_mask;
            m_addr.tag = cpu_req_addr[`ADDR_BITS-1:`ADDR_BITS-`L2_TAG_BITS];
            m_addr.w_off = cpu_req_addr[`OFFSET_BITS-1:`B_OFF_BITS];
            m_addr.b_off = cpu_req_addr[`B_OFF_BITS-1:0];
            // flush step addresses the walker set
            if (exp_next == l2_decoder_pkg::act_flush) begin
                m_addr.set = m_set[`L2_SET_BITS-1:0];
            end else begin
                m_addr.set = cpu_req_addr[`OFFSET_BITS+`L2_SET_BITS-1:`OFFSET_BITS];
            end
            if (cmd_start) begin
                m_active = 1'b1;
                m_set = '0;
                m_way = '0;
                flushes_started++;
            end else if (cmd_finish) begin
                m_active = 1'b0;
                m_set = '0;
                m_way = '0;
                flushes_completed++;
            end else if (cmd_wrap) begin
                m_way = '0;
                m_set = m_set + 1'b1;
            end else if (cmd_step) begin
                m_way = m_way + 1'b1;
            end
        end
    endtask

    task check_registers;
        compare_value("action", action, m_action);
        compare_value("line_br.tag", line_br.tag, m_line.tag);
        compare_value("line_br.set", line_br.set, m_line.set);
        compare_value("addr_br.line", addr_br.line, m_addr.line);
        compare_value("addr_br.line_addr", addr_br.line_addr, m_addr.line_addr);
        compare_value("addr_br.word", addr_br.word, m_addr.word);
        compare_value("addr_br.tag", addr_br.tag, m_addr.tag);
        compare_value("addr_br.set", addr_br.set, m_addr.set);
        compare_value("addr_br.w_off", addr_br.w_off, m_addr.w_off);
        compare_value("addr_br.b_off", addr_br.b_off, m_addr.b_off);
    endtask

    task check_outputs;
        compare_value("ready", ready, exp_ready);
        compare_value("set_cpu_req_from_conflict", set_cpu_req_from_conflict, exp_conf);
        compare_value("set_fwd_in_from_stalled", set_fwd_in_from_stalled, exp_stalled);
        compare_value("flush_done", flush_done, exp_done);
        if (flush_done) begin
            done_pulses++;
        end
        check_registers();
    endtask

    // hard stop in case the run stalls
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, run did not complete", cycle_count);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        seed = 69618;
        mismatch_count = 0;
        other_count = 0;
        flushes_started = 0;
        flushes_completed = 0;
        done_pulses = 0;
        rst = 1'b0;
        decode_en = 1'b0;
        valid = '0;
        status = '0;
        mshr_cnt = '0;
        rsp_in_addr = '0;
        fwd_in_addr = '0;
        fwd_in_tmp_addr = '0;
        cpu_req_addr = '0;
        m_action = l2_decoder_pkg::act_idle;
        m_line = '0;
        m_addr = '0;
        m_active = 1'b0;
        m_set = '0;
        m_way = '0;
        exp_next = l2_decoder_pkg::act_idle;
        {cmd_start, cmd_step, cmd_wrap, cmd_finish} = 4'b0000;

        // three edges under reset, outputs checked before release
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_value("ready", ready, '0);
        check_registers();
        @(posedge clk);
        #1 rst = 1'b1;

        repeat (num_cycles) begin
            @(posedge clk);
            advance_model();
            #1 drive_inputs();
            @(negedge clk);
            decide();
            check_outputs();
        end

        // let the last decision reach the registers
        @(posedge clk);
        advance_model();
        @(negedge clk);
        check_registers();

        compare_value("flush_done count", done_pulses, flushes_completed);
        if (flushes_completed == 0) begin
            $display("no flush walk ran to completion, %0d flushes started", flushes_started);
            other_count++;
        end
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d flushes completed",
                 mismatch_count, other_count, flushes_completed, flushes_started);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
design/l2_decoder_pkg.sv
design/l2_input_arbiter.sv
design/l2_flush_walker.sv
design/l2_decode_register.sv
design/l2_input_decoder.sv
sim/l2_input_decoder_tb.sv
